//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_DATA_WIDTH 32
`define REG_NUM        32
// x0 is hard-wired to zero
`define ZERO_REG       5'd0

// major opcodes, ALU only
`define OPCODE_OP      7'b0110011
`define OPCODE_OP_IMM  7'b0010011

// funct3 encodings
`define F3_ADD_SUB     3'b000
`define F3_SLL         3'b001
`define F3_SLT         3'b010
`define F3_SLTU        3'b011
`define F3_XOR         3'b100
`define F3_SRL_SRA     3'b101
`define F3_OR          3'b110
`define F3_AND         3'b111

// funct7, alt selects sub / sra
`define F7_BASE        7'b0000000
`define F7_ALT         7'b0100000

`endif

//--- src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } r_type_t;

    // register-immediate layout
    // imm[11:5] doubles as the shift-immediate high bits
    typedef struct packed {
        logic [11:0]                imm;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } i_type_t;

    // one 32-bit word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    // operation handed from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

//--- src/regs.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

// general purpose register file, 2 read / 1 write
module regs (
    input  logic                       clk,
    input  logic                       reset_i,

    // write port, driven by ex
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`REG_DATA_WIDTH-1:0] wdata_i,

    // read port 1, addressed by id
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    output logic [`REG_DATA_WIDTH-1:0] rdata1_o,

    // read port 2, addressed by id
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`REG_DATA_WIDTH-1:0] rdata2_o
);

    localparam int AW = `REG_ADDR_WIDTH;

    logic [`REG_DATA_WIDTH-1:0] regs_q [0:`REG_NUM-1];
    // one enable per register
    logic [`REG_NUM-1:0]        reg_we;

    // decode the write address
    // zero register never gets an enable
    for (genvar g = 0; g < `REG_NUM; g++) begin : gen_reg_we
        assign reg_we[g] = (AW'(g) != `ZERO_REG) && we_i && (waddr_i == AW'(g));
    end

    // storage, all cleared on reset
    always_ff @(posedge clk) begin
        for (int r = 0; r < `REG_NUM; r++) begin
            if (reset_i) begin
                regs_q[r] <= '0;
            end else if (reg_we[r]) begin
                regs_q[r] <= wdata_i;
            end
        end
    end

    // read 1
    // x0 first, then bypass of the write in flight, then storage
    assign rdata1_o = (raddr1_i == `ZERO_REG) ? '0 :
                      (we_i && (raddr1_i == waddr_i)) ? wdata_i :
                      regs_q[raddr1_i];

    // read 2, same priority as read 1
    assign rdata2_o = (raddr2_i == `ZERO_REG) ? '0 :
                      (we_i && (raddr2_i == waddr_i)) ? wdata_i :
                      regs_q[raddr2_i];

endmodule

//--- src/id.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

// decode stage
// classifies the word, reads operands, registers the result toward ex
module id (
    input  logic                       clk,
    input  logic                       reset_i,

    // incoming instruction
    input  logic                       instr_valid_i,
    input  rv_pkg::instr_u             instr_i,

    // register file reads, same cycle
    output logic [`REG_ADDR_WIDTH-1:0] raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0] raddr2_o,
    input  logic [`REG_DATA_WIDTH-1:0] rdata1_i,
    input  logic [`REG_DATA_WIDTH-1:0] rdata2_i,

    // to ex, all registered
    output logic                       ex_valid_o,
    output rv_pkg::alu_op_e            ex_op_o,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rd_o,
    output logic [`REG_DATA_WIDTH-1:0] ex_opa_o,
    output logic [`REG_DATA_WIDTH-1:0] ex_opb_o,

    // one-cycle pulse for a rejected word
    output logic                       illegal_o
);

    localparam int DW  = `REG_DATA_WIDTH;
    localparam int SHW = $clog2(`REG_DATA_WIDTH);
    localparam int IMW = $bits(instr_i.i.imm);

    logic                       dec_legal;
    rv_pkg::alu_op_e            dec_op;
    logic [`REG_DATA_WIDTH-1:0] dec_opb;
    logic [`REG_DATA_WIDTH-1:0] imm_sext;
    logic [`REG_DATA_WIDTH-1:0] shamt_ext;
    logic [6:0]                 imm_hi;

    logic                       ex_valid_q;
    logic                       illegal_q;
    rv_pkg::alu_op_e            ex_op_q;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd_q;
    logic [`REG_DATA_WIDTH-1:0] ex_opa_q;
    logic [`REG_DATA_WIDTH-1:0] ex_opb_q;

    // rs fields sit at the same bits in both views
    // an I-type just reads a don't-care on port 2
    assign raddr1_o = instr_i.r.rs1;
    assign raddr2_o = instr_i.r.rs2;

    // immediate views
    assign imm_sext  = {{(DW-IMW){instr_i.i.imm[IMW-1]}}, instr_i.i.imm};
    assign shamt_ext = {{(DW-SHW){1'b0}}, instr_i.i.imm[SHW-1:0]};
    assign imm_hi    = instr_i.i.imm[IMW-1:IMW-7];

    always_comb begin
        dec_legal = 1'b0;
        dec_op    = rv_pkg::ALU_ADD;
        dec_opb   = rdata2_i;
        case (instr_i.r.opcode)
            `OPCODE_OP: begin
                if (instr_i.r.funct7 == `F7_BASE) begin
                    dec_legal = 1'b1;
                    case (instr_i.r.funct3)
                        `F3_ADD_SUB: dec_op = rv_pkg::ALU_ADD;
                        `F3_SLL:     dec_op = rv_pkg::ALU_SLL;
                        `F3_SLT:     dec_op = rv_pkg::ALU_SLT;
                        `F3_SLTU:    dec_op = rv_pkg::ALU_SLTU;
                        `F3_XOR:     dec_op = rv_pkg::ALU_XOR;
                        `F3_SRL_SRA: dec_op = rv_pkg::ALU_SRL;
                        `F3_OR:      dec_op = rv_pkg::ALU_OR;
                        `F3_AND:     dec_op = rv_pkg::ALU_AND;
                    endcase
                end else if (instr_i.r.funct7 == `F7_ALT) begin
                    // alt funct7 only valid for sub and sra
                    if (instr_i.r.funct3 == `F3_ADD_SUB) begin
                        dec_legal = 1'b1;
                        dec_op    = rv_pkg::ALU_SUB;
                    end else if (instr_i.r.funct3 == `F3_SRL_SRA) begin
                        dec_legal = 1'b1;
                        dec_op    = rv_pkg::ALU_SRA;
                    end
                end
            end
            `OPCODE_OP_IMM: begin
                dec_legal = 1'b1;
                dec_opb   = imm_sext;
                case (instr_i.i.funct3)
                    `F3_ADD_SUB: dec_op = rv_pkg::ALU_ADD;
                    `F3_SLT:     dec_op = rv_pkg::ALU_SLT;
                    // unsigned compare against the sign-extended imm
                    `F3_SLTU:    dec_op = rv_pkg::ALU_SLTU;
                    `F3_XOR:     dec_op = rv_pkg::ALU_XOR;
                    `F3_OR:      dec_op = rv_pkg::ALU_OR;
                    `F3_AND:     dec_op = rv_pkg::ALU_AND;
                    `F3_SLL: begin
                        dec_op    = rv_pkg::ALU_SLL;
                        dec_opb   = shamt_ext;
                        dec_legal = (imm_hi == `F7_BASE);
                    end
                    `F3_SRL_SRA: begin
                        dec_opb = shamt_ext;
                        if (imm_hi == `F7_BASE) begin
                            dec_op = rv_pkg::ALU_SRL;
                        end else if (imm_hi == `F7_ALT) begin
                            dec_op = rv_pkg::ALU_SRA;
                        end else begin
                            dec_legal = 1'b0;
                        end
                    end
                endcase
            end
            default: begin
                // any other opcode is rejected
                dec_legal = 1'b0;
            end
        endcase
    end

    // control flops
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            ex_valid_q <= instr_valid_i && dec_legal;
            illegal_q  <= instr_valid_i && !dec_legal;
        end
    end

    // payload, only loaded for a legal word
    always_ff @(posedge clk) begin
        if (instr_valid_i && dec_legal) begin
            ex_op_q  <= dec_op;
            ex_rd_q  <= instr_i.r.rd;
            ex_opa_q <= rdata1_i;
            ex_opb_q <= dec_opb;
        end
    end

    assign ex_valid_o = ex_valid_q;
    assign illegal_o  = illegal_q;
    assign ex_op_o    = ex_op_q;
    assign ex_rd_o    = ex_rd_q;
    assign ex_opa_o   = ex_opa_q;
    assign ex_opb_o   = ex_opb_q;

endmodule

//--- src/ex.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

// execute stage
// pure ALU, result goes straight to the register file write port
module ex (
    // registered decode result from id
    input  logic                       ex_valid_i,
    input  rv_pkg::alu_op_e            ex_op_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd_i,
    input  logic [`REG_DATA_WIDTH-1:0] ex_opa_i,
    input  logic [`REG_DATA_WIDTH-1:0] ex_opb_i,

    // write port, also the write-back outputs of the top
    output logic                       we_o,
    output logic [`REG_ADDR_WIDTH-1:0] waddr_o,
    output logic [`REG_DATA_WIDTH-1:0] wdata_o
);

    localparam int DW  = `REG_DATA_WIDTH;
    localparam int SHW = $clog2(`REG_DATA_WIDTH);

    logic [SHW-1:0]             shamt;
    logic                       lt_s;
    logic                       lt_u;
    logic [`REG_DATA_WIDTH-1:0] alu_res;

    // shifts only look at the low bits of b
    assign shamt = ex_opb_i[SHW-1:0];

    // both compares, picked below
    assign lt_s = $signed(ex_opa_i) < $signed(ex_opb_i);
    assign lt_u = ex_opa_i < ex_opb_i;

    always_comb begin
        case (ex_op_i)
            rv_pkg::ALU_ADD: begin
                alu_res = ex_opa_i + ex_opb_i;
            end
            rv_pkg::ALU_SUB: begin
                alu_res = ex_opa_i - ex_opb_i;
            end
            rv_pkg::ALU_AND: begin
                alu_res = ex_opa_i & ex_opb_i;
            end
            rv_pkg::ALU_OR: begin
                alu_res = ex_opa_i | ex_opb_i;
            end
            rv_pkg::ALU_XOR: begin
                alu_res = ex_opa_i ^ ex_opb_i;
            end
            rv_pkg::ALU_SLL: begin
                alu_res = ex_opa_i << shamt;
            end
            rv_pkg::ALU_SRL: begin
                alu_res = ex_opa_i >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                // sign bit fills from the left
                alu_res = $signed(ex_opa_i) >>> shamt;
            end
            rv_pkg::ALU_SLT: begin
                alu_res = {{(DW-1){1'b0}}, lt_s};
            end
            rv_pkg::ALU_SLTU: begin
                alu_res = {{(DW-1){1'b0}}, lt_u};
            end
            default: begin
                // unused encodings
                alu_res = '0;
            end
        endcase
    end

    // write happens the cycle ex_valid_i is high
    // x0 filtering is left to regs
    assign we_o    = ex_valid_i;
    assign waddr_o = ex_rd_i;
    assign wdata_o = alu_res;

endmodule

//--- src/rv_exec_core.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

// integer execution slice: id -> ex with shared register file
module rv_exec_core (
    input  logic                       clk,
    input  logic                       reset_i,

    // instruction in
    input  logic                       instr_valid_i,
    input  rv_pkg::instr_u             instr_i,

    // write-back, one cycle after the strobe
    output logic                       wb_valid_o,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd_o,
    output logic [`REG_DATA_WIDTH-1:0] wb_data_o,

    // rejected instruction, same timing as write-back
    output logic                       illegal_o
);

    // register file reads
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic [`REG_DATA_WIDTH-1:0] rdata1;
    logic [`REG_DATA_WIDTH-1:0] rdata2;

    // id to ex
    logic                       ex_valid;
    rv_pkg::alu_op_e            ex_op;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic [`REG_DATA_WIDTH-1:0] ex_opa;
    logic [`REG_DATA_WIDTH-1:0] ex_opb;

    // ex to register file
    logic                       we;
    logic [`REG_ADDR_WIDTH-1:0] waddr;
    logic [`REG_DATA_WIDTH-1:0] wdata;

    id i_id (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .ex_valid_o    (ex_valid),
        .ex_op_o       (ex_op),
        .ex_rd_o       (ex_rd),
        .ex_opa_o      (ex_opa),
        .ex_opb_o      (ex_opb),
        .illegal_o     (illegal_o)
    );

    // write-through here covers back-to-back dependencies
    regs i_regs (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (we),
        .waddr_i  (waddr),
        .wdata_i  (wdata),
        .raddr1_i (raddr1),
        .rdata1_o (rdata1),
        .raddr2_i (raddr2),
        .rdata2_o (rdata2)
    );

    ex i_ex (
        .ex_valid_i (ex_valid),
        .ex_op_i    (ex_op),
        .ex_rd_i    (ex_rd),
        .ex_opa_i   (ex_opa),
        .ex_opb_i   (ex_opb),
        .we_o       (we),
        .waddr_o    (waddr),
        .wdata_o    (wdata)
    );

    // write port doubles as write-back
    assign wb_valid_o = we;
    assign wb_rd_o    = waddr;
    assign wb_data_o  = wdata;

endmodule

//--- verification/tb_rv_exec_core.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module tb_rv_exec_core;

    localparam int MAX_ENTRIES   = 64;
    localparam int RESET_TIMEOUT = 50;

    logic                       clk;
    logic                       reset_i;
    logic                       instr_valid_i;
    rv_pkg::instr_u             instr_i;
    logic                       wb_valid_o;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd_o;
    logic [`REG_DATA_WIDTH-1:0] wb_data_o;
    logic                       illegal_o;

    // stimulus table
    rv_pkg::instr_u             tab_instr [0:MAX_ENTRIES-1];
    logic                       tab_ill   [0:MAX_ENTRIES-1];
    logic [`REG_ADDR_WIDTH-1:0] tab_rd    [0:MAX_ENTRIES-1];
    logic [`REG_DATA_WIDTH-1:0] tab_data  [0:MAX_ENTRIES-1];
    int                         n_entries;

    // reference register contents follow the table as it is built
    logic [`REG_DATA_WIDTH-1:0] model_regs [0:`REG_NUM-1];

    int mismatch_count;
    int other_count;
    int seed;

    rv_exec_core i_rv_exec_core (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // word builders go through the union
    function automatic rv_pkg::instr_u make_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        rv_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = `OPCODE_OP;
        return w;
    endfunction

    function automatic rv_pkg::instr_u make_i(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        rv_pkg::instr_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = `OPCODE_OP_IMM;
        return w;
    endfunction

    // RV32I integer rules
    // alt picks sub or sra
    function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        logic [31:0] res;
        case (f3)
            `F3_ADD_SUB: res = alt ? (a - b) : (a + b);
            `F3_SLL:     res = a << b[4:0];
            `F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
            `F3_SLTU:    res = {31'b0, a < b};
            `F3_XOR:     res = a ^ b;
            `F3_SRL_SRA: res = alt ? 32'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            `F3_OR:      res = a | b;
            default:     res = a & b;
        endcase
        return res;
    endfunction

    task automatic add_entry(rv_pkg::instr_u w, logic ill, logic [4:0] rd, logic [31:0] data);
        tab_instr[n_entries] = w;
        tab_ill[n_entries]   = ill;
        tab_rd[n_entries]    = rd;
        tab_data[n_entries]  = data;
        n_entries++;
        // x0 stays zero in the model too
        if (!ill && rd != 5'd0) begin
            model_regs[rd] = data;
        end
    endtask

    task automatic check_wb(logic [4:0] rd, logic [31:0] data);
        if (wb_valid_o !== 1'b1 || illegal_o !== 1'b0) begin
            $display("no write-back seen for rd %0d (wb_valid_o=%b illegal_o=%b)",
                     rd, wb_valid_o, illegal_o);
            other_count++;
        end
        if (wb_rd_o !== rd) begin
            $display("MISMATCH wb_rd_o got %h expected %h", wb_rd_o, rd);
            mismatch_count++;
        end
        if (wb_data_o !== data) begin
            $display("MISMATCH wb_data_o got %h expected %h", wb_data_o, data);
            mismatch_count++;
        end
    endtask

    task automatic check_illegal();
        if (illegal_o !== 1'b1) begin
            $display("MISMATCH illegal_o got %h expected %h", illegal_o, 1'b1);
            mismatch_count++;
        end
        if (wb_valid_o !== 1'b0) begin
            $display("illegal instruction produced a write-back to rd %0d", wb_rd_o);
            other_count++;
        end
    endtask

    task automatic build_random_entries(int count);
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        logic        use_imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [31:0] opb;
        for (int k = 0; k < count; k++) begin
            rnd     = $random(seed);
            f3      = rnd[2:0];
            use_imm = rnd[3];
            // sources also cover the random destinations
            rs1     = 5'(1 + (rnd[8:4] % 20));
            rs2     = 5'(1 + (rnd[13:9] % 20));
            rd      = 5'(13 + rnd[31:29]);
            imm     = rnd[27:16];
            alt     = rnd[28] && ((f3 == `F3_SRL_SRA) || (f3 == `F3_ADD_SUB && !use_imm));
            if (use_imm) begin
                // shift-immediates carry funct7 in imm[11:5]
                if (f3 == `F3_SLL || f3 == `F3_SRL_SRA) begin
                    imm = {alt ? `F7_ALT : `F7_BASE, imm[4:0]};
                end
                opb = {{20{imm[11]}}, imm};
                add_entry(make_i(imm, rs1, f3, rd), 1'b0, rd,
                          ref_alu(f3, alt, model_regs[rs1], opb));
            end else begin
                add_entry(make_r(alt ? `F7_ALT : `F7_BASE, rs2, rs1, f3, rd), 1'b0, rd,
                          ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
            end
        end
    endtask

    task automatic build_table();
        rv_pkg::instr_u w;
        // x30 and x31 hold zero after reset
        add_entry(make_r(`F7_BASE, 5'd31, 5'd30, `F3_OR, 5'd12), 1'b0, 5'd12, 32'h0);
        // preload via addi from x0
        add_entry(make_i(12'd5, 5'd0, `F3_ADD_SUB, 5'd1), 1'b0, 5'd1, 32'h5);
        add_entry(make_i(-12'sd3, 5'd0, `F3_ADD_SUB, 5'd2), 1'b0, 5'd2, 32'hFFFF_FFFD);
        add_entry(make_i(12'd2, 5'd0, `F3_ADD_SUB, 5'd3), 1'b0, 5'd3, 32'h2);
        // register-register ops on x1 = 5, x2 = -3 and x3 = 2
        add_entry(make_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD_SUB, 5'd4), 1'b0, 5'd4, 32'h2);
        add_entry(make_r(`F7_ALT, 5'd2, 5'd1, `F3_ADD_SUB, 5'd4), 1'b0, 5'd4, 32'h8);
        add_entry(make_r(`F7_BASE, 5'd2, 5'd1, `F3_AND, 5'd5), 1'b0, 5'd5, 32'h5);
        add_entry(make_r(`F7_BASE, 5'd2, 5'd1, `F3_OR, 5'd5), 1'b0, 5'd5, 32'hFFFF_FFFD);
        add_entry(make_r(`F7_BASE, 5'd2, 5'd1, `F3_XOR, 5'd5), 1'b0, 5'd5, 32'hFFFF_FFF8);
        add_entry(make_r(`F7_BASE, 5'd3, 5'd2, `F3_SLL, 5'd6), 1'b0, 5'd6, 32'hFFFF_FFF4);
        add_entry(make_r(`F7_BASE, 5'd3, 5'd2, `F3_SRL_SRA, 5'd6), 1'b0, 5'd6, 32'h3FFF_FFFF);
        add_entry(make_r(`F7_ALT, 5'd3, 5'd2, `F3_SRL_SRA, 5'd6), 1'b0, 5'd6, 32'hFFFF_FFFF);
        // -3 < 5 signed but not unsigned
        add_entry(make_r(`F7_BASE, 5'd1, 5'd2, `F3_SLT, 5'd7), 1'b0, 5'd7, 32'h1);
        add_entry(make_r(`F7_BASE, 5'd1, 5'd2, `F3_SLTU, 5'd7), 1'b0, 5'd7, 32'h0);
        // immediate ops
        add_entry(make_i(-12'sd7, 5'd1, `F3_ADD_SUB, 5'd8), 1'b0, 5'd8, 32'hFFFF_FFFE);
        add_entry(make_i(12'h0F0, 5'd2, `F3_AND, 5'd8), 1'b0, 5'd8, 32'h0000_00F0);
        add_entry(make_i(12'h100, 5'd1, `F3_OR, 5'd8), 1'b0, 5'd8, 32'h0000_0105);
        add_entry(make_i(12'hFFF, 5'd1, `F3_XOR, 5'd8), 1'b0, 5'd8, 32'hFFFF_FFFA);
        add_entry(make_i(-12'sd2, 5'd2, `F3_SLT, 5'd9), 1'b0, 5'd9, 32'h1);
        add_entry(make_i(12'hFFF, 5'd1, `F3_SLTU, 5'd9), 1'b0, 5'd9, 32'h1);
        add_entry(make_i(12'd4, 5'd1, `F3_SLL, 5'd9), 1'b0, 5'd9, 32'h50);
        add_entry(make_i(12'd28, 5'd2, `F3_SRL_SRA, 5'd9), 1'b0, 5'd9, 32'hF);
        add_entry(make_i({`F7_ALT, 5'd1}, 5'd2, `F3_SRL_SRA, 5'd9), 1'b0, 5'd9, 32'hFFFF_FFFE);
        // dependent chain through the bypass
        add_entry(make_i(12'd1, 5'd0, `F3_ADD_SUB, 5'd10), 1'b0, 5'd10, 32'h1);
        add_entry(make_r(`F7_BASE, 5'd10, 5'd10, `F3_ADD_SUB, 5'd10), 1'b0, 5'd10, 32'h2);
        add_entry(make_i(12'd3, 5'd10, `F3_SLL, 5'd10), 1'b0, 5'd10, 32'h10);
        add_entry(make_r(`F7_ALT, 5'd1, 5'd10, `F3_ADD_SUB, 5'd11), 1'b0, 5'd11, 32'hB);
        add_entry(make_r(`F7_BASE, 5'd10, 5'd11, `F3_XOR, 5'd11), 1'b0, 5'd11, 32'h1B);
        // x0 write pulses write-back and then reads back zero
        add_entry(make_i(12'd7, 5'd1, `F3_ADD_SUB, 5'd0), 1'b0, 5'd0, 32'hC);
        add_entry(make_r(`F7_BASE, 5'd0, 5'd0, `F3_ADD_SUB, 5'd5), 1'b0, 5'd5, 32'h0);
        // illegal words are a load opcode, a mul funct7 and bad slli high bits
        w        = make_i(12'd4, 5'd1, `F3_ADD_SUB, 5'd1);
        w.r.opcode = 7'b0000011;
        add_entry(w, 1'b1, 5'd0, 32'h0);
        add_entry(make_r(7'b0000001, 5'd2, 5'd1, `F3_ADD_SUB, 5'd1), 1'b1, 5'd0, 32'h0);
        add_entry(make_i({`F7_ALT, 5'd1}, 5'd1, `F3_SLL, 5'd1), 1'b1, 5'd0, 32'h0);
        // x1 still 5
        add_entry(make_r(`F7_BASE, 5'd0, 5'd1, `F3_ADD_SUB, 5'd12), 1'b0, 5'd12, 32'h5);
        build_random_entries(16);
    endtask

    task automatic check_entry(int k);
        if (tab_ill[k]) begin
            check_illegal();
        end else begin
            check_wb(tab_rd[k], tab_data[k]);
        end
    endtask

    initial begin
        int wait_cycles;
        seed           = 32'h6aea4d65;
        mismatch_count = 0;
        other_count    = 0;
        n_entries      = 0;
        reset_i        = 1'b1;
        // strobe held through reset must never reach x31
        instr_valid_i  = 1'b1;
        instr_i        = make_i(12'h123, 5'd0, `F3_ADD_SUB, 5'd31);
        for (int r = 0; r < `REG_NUM; r++) begin
            model_regs[r] = '0;
        end
        build_table();

        repeat (10) @(negedge clk);
        reset_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;

        // outputs must settle quiet after reset
        wait_cycles = 0;
        while (wb_valid_o !== 1'b0 || illegal_o !== 1'b0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("timeout waiting for quiet outputs after reset");
                $display("Test failures found");
                $finish;
            end
        end

        // back to back with entry k checked while k+1 is driven
        for (int k = 0; k < n_entries; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_entry(k - 1);
            end
            instr_valid_i = 1'b1;
            instr_i       = tab_instr[k];
        end
        @(negedge clk);
        check_entry(n_entries - 1);
        instr_valid_i = 1'b0;
        instr_i       = '0;
        @(negedge clk);
        if (wb_valid_o !== 1'b0 || illegal_o !== 1'b0) begin
            $display("output pulse seen with no instruction strobed");
            other_count++;
        end

        $display("entries %0d, mismatches %0d, other errors %0d",
                 n_entries, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/rv_pkg.sv
src/regs.sv
src/id.sv
src/ex.sv
src/rv_exec_core.sv
verification/tb_rv_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log

verilator --binary --timing -f verilog.f --top-module tb_rv_exec_core \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "All tests passed!" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
